// File: hw/vicPkg.sv
`default_nettype none

package vicPkg;

  // dot position within a raster line
  typedef logic [9:0] rasterX_t;
  // raster line number
  typedef logic [8:0] rasterY_t;
  // palette index, 16 colours
  typedef logic [3:0] vicColor_t;
  // register index as presented on adi
  typedef logic [5:0] regAddr_t;

  // register map, only the registers this core implements
  localparam regAddr_t regCtrl1 = 6'h11;
  localparam regAddr_t regRaster = 6'h12;
  localparam regAddr_t regCtrl2 = 6'h16;
  localparam regAddr_t regIrqStatus = 6'h19;
  localparam regAddr_t regIrqEnable = 6'h1A;
  localparam regAddr_t regBorderColor = 6'h20;
  localparam regAddr_t regBgColor0 = 6'h21;

  // tick numbers inside the 32 tick phi cycle
  // cpu write data is stable by tick 7 of phi high
  localparam logic [4:0] tickRegWrite = 5'd23;
  localparam logic [4:0] tickPhiRise = 5'd16;

  // lines on which bad lines may occur
  localparam rasterY_t firstDisplayLine = 9'd48;
  localparam rasterY_t lastDisplayLine = 9'd248;

  // vertical border, 25 row and 24 row variants
  localparam rasterY_t borderOpen25 = 9'd51;
  localparam rasterY_t borderOpen24 = 9'd55;
  localparam rasterY_t borderClose25 = 9'd251;
  localparam rasterY_t borderClose24 = 9'd247;

  // horizontal border, 40 column and 38 column variants
  localparam rasterX_t leftOpen40 = 10'd24;
  localparam rasterX_t leftOpen38 = 10'd31;
  localparam rasterX_t rightClose40 = 10'd344;
  localparam rasterX_t rightClose38 = 10'd335;

endpackage

`default_nettype wire

// File: hw/vicTimingIf.sv
`timescale 1ns/1ps
`default_nettype none

interface vicTimingIf;

  // one tick pulse where the dot clock rises
  logic dotRise;
  // same level as clkPhi
  logic phiHigh;
  // tick index within the phi cycle, 0 to 31
  logic [4:0] phaseTick;
  // last tick of the phi cycle
  logic phiEnd;

  modport source(output dotRise, phiHigh, phaseTick, phiEnd);
  modport sink(input dotRise, phiHigh, phaseTick, phiEnd);

endinterface

`default_nettype wire

// File: hw/vicCtrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface vicCtrlIf;

  // fields of control registers 1 and 2
  logic [2:0] yScroll;
  logic den;
  logic rsel;
  logic csel;

  modport source(output yScroll, den, rsel, csel);
  modport sink(input yScroll, den, rsel, csel);

endinterface

`default_nettype wire

// File: hw/phaseGen.sv
`timescale 1ns/1ps
`default_nettype none

module phaseGen (
  input wire clk_dot4x,
  input wire rst,
  vicTimingIf.source timing,
  output logic clkDot,
  output logic clkPhi
);

  logic [31:0] phiRing;
  logic [3:0] dotRing;
  logic [4:0] tickCnt;

  // rings rotate right, so bit 0 at tick t is the reset bit t
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      // phi low for ticks 0 to 15, high for 16 to 31
      phiRing <= 32'hFFFF_0000;
      // dot high on ticks 3 and 0 of each group of four
      dotRing <= 4'b1001;
      tickCnt <= 5'd0;
    end else begin
      phiRing <= {phiRing[0], phiRing[31:1]};
      dotRing <= {dotRing[0], dotRing[3:1]};
      tickCnt <= tickCnt + 5'd1;
    end
  end

  assign clkPhi = phiRing[0];
  assign clkDot = dotRing[0];

  assign timing.phiHigh = phiRing[0];
  assign timing.phaseTick = tickCnt;
  // dot rises on the last tick of each group, so rasterX steps in line with phi
  assign timing.dotRise = (tickCnt[1:0] == 2'd3);
  assign timing.phiEnd = (tickCnt == 5'd31);

endmodule

`default_nettype wire

// File: hw/rasterCounter.sv
`timescale 1ns/1ps
`default_nettype none

module rasterCounter
  import vicPkg::*;
#(
  parameter int dotsPerLine = 504,
  parameter int linesPerFrame = 312
) (
  input wire clk_dot4x,
  input wire rst,
  vicTimingIf.sink timing,
  output rasterX_t rasterX,
  output rasterY_t rasterLine,
  output logic startOfLine
);

  localparam rasterX_t lastDot = rasterX_t'(dotsPerLine - 1);
  localparam rasterY_t lastLine = rasterY_t'(linesPerFrame - 1);

  logic lineDue;
  logic frameDue;
  logic [6:0] cycleNum;

  // eight dots per phi cycle
  assign cycleNum = rasterX[9:3];

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterX <= '0;
      rasterLine <= '0;
      lineDue <= 1'b0;
      frameDue <= 1'b0;
      startOfLine <= 1'b0;
    end else begin
      startOfLine <= 1'b0;
      if (timing.dotRise) begin
        if (rasterX == lastDot) begin
          rasterX <= '0;
          // line change waits for phi high of the new line
          if (rasterLine == lastLine)
            frameDue <= 1'b1;
          else
            lineDue <= 1'b1;
        end else begin
          rasterX <= rasterX + 10'd1;
        end
      end
      if (timing.phaseTick == tickPhiRise) begin
        // frame wrap lands one cycle later than a normal line step
        if (frameDue && cycleNum == 7'd1) begin
          rasterLine <= '0;
          frameDue <= 1'b0;
          startOfLine <= 1'b1;
        end else if (lineDue && cycleNum == 7'd0) begin
          rasterLine <= rasterLine + 9'd1;
          lineDue <= 1'b0;
          startOfLine <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/badLineCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module badLineCtrl
  import vicPkg::*;
#(
  parameter int dotsPerLine = 504
) (
  input wire clk_dot4x,
  input wire rst,
  vicTimingIf.sink timing,
  vicCtrlIf.sink ctrl,
  input wire rasterX_t rasterX,
  input wire rasterY_t rasterLine,
  input wire startOfLine,
  output logic allowBadLines,
  output logic ba,
  output logic aec
);

  // ba window ends ten cycles before the last cycle of the line
  localparam logic [6:0] baFirstCycle = 7'd11;
  localparam logic [6:0] baLastCycle = 7'(dotsPerLine / 8 - 10);

  logic [2:0] yScrollLatched;
  logic badLine;
  logic ba1;
  logic ba2;
  logic ba3;
  logic [6:0] cycleNum;

  assign cycleNum = rasterX[9:3];

  // den is sampled anywhere on line 48, window closes at line 248
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      allowBadLines <= 1'b0;
    end else begin
      if (timing.dotRise && rasterLine == firstDisplayLine && ctrl.den)
        allowBadLines <= 1'b1;
      if (startOfLine && rasterLine == lastDisplayLine)
        allowBadLines <= 1'b0;
    end
  end

  // yScroll takes effect one phi high later than the register write
  always_ff @(posedge clk_dot4x) begin
    if (rst)
      yScrollLatched <= 3'd0;
    else if (timing.phaseTick == tickPhiRise)
      yScrollLatched <= ctrl.yScroll;
  end

  assign badLine = allowBadLines && (rasterLine[2:0] == yScrollLatched) &&
                   (rasterLine >= firstDisplayLine) && (rasterLine < lastDisplayLine);

  // ba only moves on dot edges in the vic half
  always_ff @(posedge clk_dot4x) begin
    if (rst)
      ba <= 1'b1;
    else if (timing.dotRise && !timing.phiHigh)
      ba <= !(badLine && cycleNum >= baFirstCycle && cycleNum <= baLastCycle);
  end

  // three stage history of ba, shifted as phi goes low
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      ba1 <= 1'b1;
      ba2 <= 1'b1;
      ba3 <= 1'b1;
    end else if (timing.phiEnd) begin
      ba1 <= ba;
      ba2 <= ba1 | ba;
      ba3 <= ba2 | ba;
    end
  end

  // cpu keeps phi high for three more cycles after ba falls
  always_ff @(posedge clk_dot4x) begin
    if (rst)
      aec <= 1'b0;
    else
      aec <= ba ? timing.phiHigh : (ba3 & timing.phiHigh);
  end

endmodule

`default_nettype wire

// File: hw/vicRegs.sv
`timescale 1ns/1ps
`default_nettype none

module vicRegs
  import vicPkg::*;
(
  input wire clk_dot4x,
  input wire rst,
  vicTimingIf.sink timing,
  vicCtrlIf.source ctrl,
  input wire rasterX_t rasterX,
  input wire rasterY_t rasterLine,
  input wire startOfLine,
  input wire regAddr_t adi,
  input wire [7:0] dbi,
  output logic [7:0] dbo,
  input wire ce,
  input wire rw,
  output logic irq,
  output vicColor_t borderColor,
  output vicColor_t bgColor0
);

  logic [2:0] yScroll;
  logic den;
  logic rsel;
  logic csel;
  rasterY_t rasterCmp;
  logic rasterIrq;
  logic rasterIrqEn;
  logic rasterIrqDone;
  logic rasterHit;
  logic writeStrobe;
  logic [6:0] cycleNum;

  assign cycleNum = rasterX[9:3];
  // compare point is cycle 0, or cycle 1 on line 0 since that line starts late
  assign rasterHit = (rasterLine == rasterCmp) &&
                     (cycleNum == ((rasterLine == '0) ? 7'd1 : 7'd0));
  // cpu data is taken once per phi cycle
  assign writeStrobe = !ce && !rw && (timing.phaseTick == tickRegWrite);

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      yScroll <= 3'd3;
      den <= 1'b1;
      rsel <= 1'b0;
      csel <= 1'b0;
      rasterCmp <= '0;
      rasterIrqEn <= 1'b0;
      borderColor <= '0;
      bgColor0 <= '0;
    end else if (writeStrobe) begin
      case (adi)
        regCtrl1: begin
          yScroll <= dbi[2:0];
          rsel <= dbi[3];
          den <= dbi[4];
          // bit 7 is the ninth compare bit
          rasterCmp[8] <= dbi[7];
        end
        regRaster: rasterCmp[7:0] <= dbi;
        regCtrl2: csel <= dbi[3];
        regIrqEnable: rasterIrqEn <= dbi[0];
        regBorderColor: borderColor <= dbi[3:0];
        regBgColor0: bgColor0 <= dbi[3:0];
        default: ;
      endcase
    end
  end

  // status latch, set at most once per line, cleared by writing a 1
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      rasterIrq <= 1'b0;
      rasterIrqDone <= 1'b0;
    end else begin
      if (writeStrobe && adi == regIrqStatus && dbi[0])
        rasterIrq <= 1'b0;
      if (startOfLine) begin
        // new line re-arms the guard
        rasterIrqDone <= rasterHit;
        if (rasterHit)
          rasterIrq <= 1'b1;
      end else if (rasterHit && !rasterIrqDone) begin
        rasterIrqDone <= 1'b1;
        rasterIrq <= 1'b1;
      end
    end
  end

  // status is latched even while disabled
  assign irq = rasterIrq & rasterIrqEn;

  // read mux, unused bits float high
  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      dbo <= 8'h00;
    end else if (!ce && rw) begin
      case (adi)
        regCtrl1: dbo <= {rasterLine[8], 2'b11, den, rsel, yScroll};
        regRaster: dbo <= rasterLine[7:0];
        regCtrl2: dbo <= {4'b1111, csel, 3'b111};
        regIrqStatus: dbo <= {irq, 6'b111111, rasterIrq};
        regIrqEnable: dbo <= {7'b1111111, rasterIrqEn};
        regBorderColor: dbo <= {4'b1111, borderColor};
        regBgColor0: dbo <= {4'b1111, bgColor0};
        default: dbo <= 8'hFF;
      endcase
    end
  end

  assign ctrl.yScroll = yScroll;
  assign ctrl.den = den;
  assign ctrl.rsel = rsel;
  assign ctrl.csel = csel;

endmodule

`default_nettype wire

// File: hw/borderGen.sv
`timescale 1ns/1ps
`default_nettype none

module borderGen
  import vicPkg::*;
(
  input wire clk_dot4x,
  input wire rst,
  vicTimingIf.sink timing,
  vicCtrlIf.sink ctrl,
  input wire rasterX_t rasterX,
  input wire rasterY_t rasterLine,
  input wire allowBadLines,
  input wire vicColor_t borderColor,
  input wire vicColor_t bgColor0,
  output vicColor_t pixelColor
);

  logic tbBorder;
  logic lrBorder;
  logic tbNext;
  rasterX_t leftDot;
  rasterX_t rightDot;

  // vertical border state, applied at the left edge of the window
  always_comb begin
    tbNext = tbBorder;
    if (allowBadLines && rasterLine == borderOpen24)
      tbNext = 1'b0;
    if (allowBadLines && ctrl.rsel && rasterLine == borderOpen25)
      tbNext = 1'b0;
    if (!ctrl.rsel && rasterLine == borderClose24)
      tbNext = 1'b1;
    if (ctrl.rsel && rasterLine == borderClose25)
      tbNext = 1'b1;
  end

  // csel picks the 40 or 38 column window
  assign leftDot = ctrl.csel ? leftOpen40 : leftOpen38;
  assign rightDot = ctrl.csel ? rightClose40 : rightClose38;

  always_ff @(posedge clk_dot4x) begin
    if (rst) begin
      tbBorder <= 1'b1;
      lrBorder <= 1'b1;
      pixelColor <= '0;
    end else begin
      if (timing.dotRise) begin
        if (rasterX == leftDot) begin
          lrBorder <= tbNext;
          tbBorder <= tbNext;
        end
        if (rasterX == rightDot)
          lrBorder <= 1'b1;
      end
      // either flag puts the border colour on screen
      pixelColor <= (tbBorder || lrBorder) ? borderColor : bgColor0;
    end
  end

endmodule

`default_nettype wire

// File: hw/vicCore.sv
`timescale 1ns/1ps
`default_nettype none

module vicCore
  import vicPkg::*;
#(
  // PAL 6569 raster geometry
  parameter int dotsPerLine = 504,
  parameter int linesPerFrame = 312
) (
  input wire clk_dot4x,
  input wire rst,
  input wire regAddr_t adi,
  input wire [7:0] dbi,
  output logic [7:0] dbo,
  input wire ce,
  input wire rw,
  output logic irq,
  output logic ba,
  output logic aec,
  output logic clkDot,
  output logic clkPhi,
  output vicColor_t pixelColor
);

  rasterX_t rasterX;
  rasterY_t rasterLine;
  logic startOfLine;
  logic allowBadLines;
  vicColor_t borderColor;
  vicColor_t bgColor0;

  vicTimingIf timingBus ();
  vicCtrlIf ctrlBus ();

  phaseGen phaseGen_i (
    .clk_dot4x(clk_dot4x),
    .rst(rst),
    .timing(timingBus.source),
    .clkDot(clkDot),
    .clkPhi(clkPhi)
  );

  rasterCounter #(
    .dotsPerLine(dotsPerLine),
    .linesPerFrame(linesPerFrame)
  ) rasterCounter_i (
    .clk_dot4x(clk_dot4x),
    .rst(rst),
    .timing(timingBus.sink),
    .rasterX(rasterX),
    .rasterLine(rasterLine),
    .startOfLine(startOfLine)
  );

  badLineCtrl #(
    .dotsPerLine(dotsPerLine)
  ) badLineCtrl_i (
    .clk_dot4x(clk_dot4x),
    .rst(rst),
    .timing(timingBus.sink),
    .ctrl(ctrlBus.sink),
    .rasterX(rasterX),
    .rasterLine(rasterLine),
    .startOfLine(startOfLine),
    .allowBadLines(allowBadLines),
    .ba(ba),
    .aec(aec)
  );

  vicRegs vicRegs_i (
    .clk_dot4x(clk_dot4x),
    .rst(rst),
    .timing(timingBus.sink),
    .ctrl(ctrlBus.source),
    .rasterX(rasterX),
    .rasterLine(rasterLine),
    .startOfLine(startOfLine),
    .adi(adi),
    .dbi(dbi),
    .dbo(dbo),
    .ce(ce),
    .rw(rw),
    .irq(irq),
    .borderColor(borderColor),
    .bgColor0(bgColor0)
  );

  borderGen borderGen_i (
    .clk_dot4x(clk_dot4x),
    .rst(rst),
    .timing(timingBus.sink),
    .ctrl(ctrlBus.sink),
    .rasterX(rasterX),
    .rasterLine(rasterLine),
    .allowBadLines(allowBadLines),
    .borderColor(borderColor),
    .bgColor0(bgColor0),
    .pixelColor(pixelColor)
  );

endmodule

`default_nettype wire

// File: tb/vicTbTasks.svh
`ifndef VIC_TB_TASKS_SVH
`define VIC_TB_TASKS_SVH

// hand a value pair to the compare process
task automatic queueCheck(input int id, input string name, input int exp, input int act);
  idQ.push_back(id);
  nameQ.push_back(name);
  expQ.push_back(exp);
  actQ.push_back(act);
  checksQueued++;
endtask

// wait until every queued check has been compared, then report the test
task automatic finishTest(input int id);
  wait (checksDone == checksQueued);
  if (testErrors[id] == 0)
    $display("test %0d %s: ok", id + 1, testNames[id]);
  else
    $display("test %0d %s: %0d errors", id + 1, testNames[id], testErrors[id]);
endtask

// falling edge in tick 0, phi just went low
task automatic alignPhi();
  while (!(phiLast && !clkPhi))
    @(negedge clk_dot4x);
endtask

task automatic idlePhi(input int cycles);
  repeat (cycles * 32) @(negedge clk_dot4x);
endtask

// one full phi cycle with ce low, ends at tick 0 of the next cycle
task automatic busCycle(input regAddr_t adr, input logic isRead, input logic [7:0] data,
                        output logic [7:0] got);
  alignPhi();
  adi = adr;
  dbi = data;
  rw = isRead;
  ce = 1'b0;
  repeat (32) @(negedge clk_dot4x);
  got = dbo;
  ce = 1'b1;
  rw = 1'b1;
endtask

task automatic writeReg(input regAddr_t adr, input logic [7:0] data);
  logic [7:0] unused;
  busCycle(adr, 1'b0, data, unused);
endtask

task automatic readReg(input regAddr_t adr, output logic [7:0] data);
  busCycle(adr, 1'b1, 8'h00, data);
endtask

// bit 8 from 0x11, low byte from 0x12
task automatic readLine(output rasterY_t line);
  logic [7:0] hi;
  logic [7:0] lo;
  readReg(regCtrl1, hi);
  readReg(regRaster, lo);
  line = {hi[7], lo};
endtask

// returns a cycle or two after the line starts
task automatic waitLine(input rasterY_t target);
  rasterY_t line;
  readLine(line);
  while (line != target)
    readLine(line);
endtask

// sample ba and aec at tick 20, inside phi high
task automatic countBa(input int cycles, output int baLow, output int aecHigh);
  baLow = 0;
  aecHigh = 0;
  repeat (cycles) begin
    repeat (20) @(negedge clk_dot4x);
    if (!ba) begin
      baLow++;
      if (aec)
        aecHigh++;
    end
    repeat (12) @(negedge clk_dot4x);
  end
endtask

`endif

// File: tb/vicTb.sv
`timescale 1ns/1ps
`default_nettype none

module vicTb
  import vicPkg::*;
();

  // PAL 6569 geometry, same values the core uses
  localparam int dotsPerLine = 504;
  localparam int linesPerFrame = 312;
  // three frames of ticks plus some slack
  localparam int wdTicks = 3 * dotsPerLine * linesPerFrame * 4 + 50000;

  logic clk_dot4x;
  logic rst;
  regAddr_t adi;
  logic [7:0] dbi;
  logic [7:0] dbo;
  logic ce;
  logic rw;
  logic irq;
  logic ba;
  logic aec;
  logic clkDot;
  logic clkPhi;
  vicColor_t pixelColor;

  // clkPhi one tick back, marks the start of a phi cycle
  logic phiLast = 1'b0;

  // pending checks, consumed by the compare process
  int idQ[$];
  string nameQ[$];
  int expQ[$];
  int actQ[$];
  int checksQueued = 0;
  int checksDone = 0;
  int errors = 0;
  int testErrors[6] = '{default: 0};
  string testNames[6] = '{"reset and clocks", "register readback", "raster line",
                          "raster interrupt", "bad line ba aec", "border colour"};
  regAddr_t wrRegs[5] = '{regCtrl1, regCtrl2, regIrqEnable, regBorderColor, regBgColor0};
  integer seed = 75507;

  vicCore #(
    .dotsPerLine(dotsPerLine),
    .linesPerFrame(linesPerFrame)
  ) vicCore_i (
    .clk_dot4x(clk_dot4x),
    .rst(rst),
    .adi(adi),
    .dbi(dbi),
    .dbo(dbo),
    .ce(ce),
    .rw(rw),
    .irq(irq),
    .ba(ba),
    .aec(aec),
    .clkDot(clkDot),
    .clkPhi(clkPhi),
    .pixelColor(pixelColor)
  );

  `include "vicTbTasks.svh"

  initial begin
    clk_dot4x = 1'b0;
    forever #20 clk_dot4x = ~clk_dot4x;
  end

  always @(posedge clk_dot4x) begin
    phiLast <= clkPhi;
  end

  // register read value from the register map rules
  // wr is the last value written, or {irq, status} for 0x19
  function automatic logic [7:0] expectedRead(regAddr_t r, logic [7:0] wr, rasterY_t line);
    case (r)
      regCtrl1: return {line[8], 2'b11, wr[4:0]};
      regRaster: return line[7:0];
      regCtrl2: return {4'hF, wr[3], 3'b111};
      regIrqStatus: return {wr[7], 6'h3F, wr[0]};
      regIrqEnable: return {7'h7F, wr[0]};
      regBorderColor, regBgColor0: return {4'hF, wr[3:0]};
      default: return 8'hFF;
    endcase
  endfunction

  initial begin : compareProc
    int id;
    string name;
    int e;
    int a;
    forever begin
      wait (expQ.size() > 0);
      id = idQ.pop_front();
      name = nameQ.pop_front();
      e = expQ.pop_front();
      a = actQ.pop_front();
      assert (a == e) else begin
        $display("Mismatch in %s, %s: expected 0x%0h, actual 0x%0h",
                 testNames[id], name, e, a);
        errors++;
        testErrors[id]++;
      end
      checksDone++;
    end
  end

  initial begin : watchdog
    repeat (wdTicks) @(posedge clk_dot4x);
    $display("Timeout: the test sequence did not finish within three frames");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin : testSequence
    int i;
    int cnt;
    int aecCnt;
    int prevLine;
    logic [7:0] wr;
    logic [7:0] got;
    logic [7:0] border;
    logic [7:0] bg;
    logic phiSeen[32];
    logic dotSeen[32];
    rasterY_t line;
    regAddr_t adr;
    rst = 1'b1;
    ce = 1'b1;
    rw = 1'b1;
    adi = '0;
    dbi = 8'h00;
    repeat (16) @(negedge clk_dot4x);
    rst = 1'b0;
    // outputs still hold their reset values here
    queueCheck(0, "irq after reset", 0, irq);
    queueCheck(0, "ba after reset", 1, ba);
    queueCheck(0, "aec after reset", 0, aec);
    queueCheck(0, "dbo after reset", 0, dbo);
    queueCheck(0, "pixel after reset", 0, pixelColor);
    alignPhi();
    for (i = 0; i < 32; i++) begin
      phiSeen[i] = clkPhi;
      dotSeen[i] = clkDot;
      @(negedge clk_dot4x);
    end
    cnt = 0;
    aecCnt = 0;
    for (i = 0; i < 32; i++) begin
      if (phiSeen[i] == (i >= 16))
        cnt++;
      // dot clock must flip every second tick
      if (i >= 2 && dotSeen[i] != dotSeen[i - 2])
        aecCnt++;
    end
    queueCheck(0, "clkPhi ticks in phase", 32, cnt);
    queueCheck(0, "clkDot toggles", 30, aecCnt);
    finishTest(0);

    // still on the first lines after reset, raster bit 8 is clear
    line = '0;
    for (i = 0; i < 10; i++) begin
      adr = wrRegs[i % 5];
      wr = $random(seed);
      writeReg(adr, wr);
      readReg(adr, got);
      queueCheck(1, $sformatf("readback 0x%0h", adr), expectedRead(adr, wr, line), got);
    end
    finishTest(1);

    // one read per line, sample points exactly one line apart
    readReg(regRaster, got);
    prevLine = got;
    for (i = 0; i < 4; i++) begin
      idlePhi(62);
      readReg(regRaster, got);
      queueCheck(2, "raster step", (prevLine + 1) % linesPerFrame, got);
      prevLine = got;
    end
    finishTest(2);

    // den on, rsel on, yScroll 3, 40 columns
    writeReg(regCtrl1, 8'h1B);
    writeReg(regCtrl2, 8'h08);
    writeReg(regRaster, 8'd60);
    writeReg(regIrqStatus, 8'h01);
    writeReg(regIrqEnable, 8'h01);
    queueCheck(3, "irq before compare line", 0, irq);
    waitLine(9'd60);
    queueCheck(3, "irq at compare line", 1, irq);
    readReg(regIrqStatus, got);
    queueCheck(3, "status at compare line", expectedRead(regIrqStatus, 8'h81, '0), got);
    writeReg(regIrqStatus, 8'h01);
    queueCheck(3, "irq after clear", 0, irq);
    writeReg(regIrqEnable, 8'h00);

    border = $random(seed);
    bg = $random(seed);
    if (bg[3:0] == border[3:0])
      bg[3:0] = ~border[3:0];
    writeReg(regBorderColor, border);
    writeReg(regBgColor0, bg);
    // next frame, top border still closed
    waitLine(9'd20);
    cnt = 0;
    for (i = 0; i < 60 * 32; i++) begin
      @(negedge clk_dot4x);
      if (pixelColor == border[3:0])
        cnt++;
    end
    queueCheck(5, "border ticks on line 20", 60 * 32, cnt);

    waitLine(9'd51);
    countBa(60, cnt, aecCnt);
    queueCheck(4, "ba low cycles line 51", 43, cnt);
    queueCheck(4, "aec high cycles in ba window", 3, aecCnt);
    waitLine(9'd52);
    countBa(60, cnt, aecCnt);
    queueCheck(4, "ba low cycles line 52", 0, cnt);
    finishTest(4);

    // compare line again, now with the interrupt disabled
    waitLine(9'd60);
    cnt = 0;
    for (i = 0; i < 40 * 32; i++) begin
      @(negedge clk_dot4x);
      if (irq)
        cnt++;
    end
    queueCheck(3, "irq ticks while disabled", 0, cnt);
    readReg(regIrqStatus, got);
    queueCheck(3, "status while disabled", expectedRead(regIrqStatus, 8'h01, '0), got);
    finishTest(3);

    // middle of the display window, about dot 200
    waitLine(9'd100);
    repeat (200 * 4) @(negedge clk_dot4x);
    queueCheck(5, "background at dot 200", bg[3:0], pixelColor);
    finishTest(5);

    $display("tests 6, checks %0d, errors %0d", checksDone, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tb
hw/vicPkg.sv
hw/vicTimingIf.sv
hw/vicCtrlIf.sv
hw/phaseGen.sv
hw/rasterCounter.sv
hw/badLineCtrl.sv
hw/vicRegs.sv
hw/borderGen.sv
hw/vicCore.sv
tb/vicTb.sv

// File: Bender.yml
package:
  name: vic_core

sources:
  - files:
      - hw/vicPkg.sv
      - hw/vicTimingIf.sv
      - hw/vicCtrlIf.sv
      - hw/phaseGen.sv
      - hw/rasterCounter.sv
      - hw/badLineCtrl.sv
      - hw/vicRegs.sv
      - hw/borderGen.sv
      - hw/vicCore.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/vicTb.sv
